// File: riscv_stimulus.txt
# P: program word (hex). W: expected register write, rd and value (hex).
# S: expected store, byte address and value (hex). Text after # is ignored.
P 00500093  # addi x1, x0, 5
P ffd00113  # addi x2, x0, -3
P 002081b3  # add  x3, x1, x2
P 40118233  # sub  x4, x3, x1
P 001222b3  # slt  x5, x4, x1
P 0040a333  # slt  x6, x1, x4
P 06c00393  # addi x7, x0, 0x6c
P 0013f433  # and  x8, x7, x1
P 003464b3  # or   x9, x8, x3
P 00708013  # addi x0, x1, 7
P 00900533  # add  x10, x0, x9
P 00902423  # sw   x9, 8(x0)
P 00802583  # lw   x11, 8(x0)
P 00b58633  # add  x12, x11, x11
P 00c02623  # sw   x12, 12(x0)
P 00508463  # beq  x1, x5, +8 not taken
P 00100693  # addi x13, x0, 1
P 00030863  # beq  x6, x0, +16 taken
P 06300713  # addi x14, x0, 99 flushed
P 00102023  # sw   x1, 0(x0) flushed
P 04d00793  # addi x15, x0, 77 flushed
P 00c02803  # lw   x16, 12(x0)
P 40d808b3  # sub  x17, x16, x13
P 01102823  # sw   x17, 16(x0)
P 00000063  # beq  x0, x0, 0 self-loop
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 fffffffd
W 05 00000001
W 06 00000000
W 07 0000006c
W 08 00000004
W 09 00000006
W 0a 00000006
W 0b 00000006
W 0c 0000000c
W 0d 00000001
W 10 0000000c
W 11 0000000b
S 00000008 00000006
S 0000000c 0000000c
S 00000010 0000000b

// File: riscv.f
riscv_pkg.sv
riscv_control.sv
riscv_regfile.sv
riscv_alu.sv
riscv_immgen.sv
riscv_imem.sv
riscv_dmem.sv
riscv_core.sv
tb_riscv.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the riscv_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_riscv -f riscv.f -o tb_riscv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_riscv 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
    exit 0
fi
exit 1

// File: tb_riscv.sv
`timescale 1ns/1ns
`default_nettype none

module tb_riscv;
    import riscv_pkg::*;

    localparam int clk_period   = 100;
    localparam int drive_delay  = 10;
    localparam int reset_cycles = 8;
    localparam int quiet_cycles = 50;

    // ASCII codes of the line tags in the stimulus file.
    localparam int tag_comment  = 35;
    localparam int tag_program  = 80;
    localparam int tag_wb       = 87;
    localparam int tag_store    = 83;

    logic                   clk;
    logic                   reset;
    logic                   run;
    logic                   imem_we;
    logic [imem_addr_w-1:0] imem_addr;
    logic [xlen-1:0]        imem_wdata;
    logic                   wb_valid;
    logic [reg_addr_w-1:0]  wb_rd;
    logic [xlen-1:0]        wb_data;
    logic                   st_valid;
    logic [xlen-1:0]        st_addr;
    logic [xlen-1:0]        st_data;

    logic [xlen-1:0]       program_words [$];
    logic [reg_addr_w-1:0] exp_wb_rd [$];
    logic [xlen-1:0]       exp_wb_data [$];
    logic [xlen-1:0]       exp_st_addr [$];
    logic [xlen-1:0]       exp_st_data [$];
    int                    n_wb;
    int                    n_st;
    int                    wb_seen;
    int                    st_seen;
    int                    value_errors;
    int                    event_errors;
    int                    watchdog_cycles;

    riscv_core i_dut (
        .clk(clk), .reset(reset), .run(run),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    // Unused instruction words hold addi x31, x0, <word index>.
    function automatic logic [xlen-1:0] filler_word(input int idx);
        filler_word = {idx[11:0], 5'd0, 3'b000, 5'd31, op_itype};
    endfunction

    task automatic read_stimulus(output logic ok);
        int          fd;
        int          ch;
        int          code;
        logic [31:0] a;
        logic [31:0] b;
        ok = 1'b0;
        fd = $fopen("riscv_stimulus.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == tag_comment) begin
                    while (ch != -1 && ch != 10) ch = $fgetc(fd);
                end else if (ch == tag_program) begin
                    code = $fscanf(fd, "%h", a);
                    if (code != 1) ok = 1'b0;
                    program_words.push_back(a);
                end else if (ch == tag_wb) begin
                    code = $fscanf(fd, "%h %h", a, b);
                    if (code != 2) ok = 1'b0;
                    exp_wb_rd.push_back(a[reg_addr_w-1:0]);
                    exp_wb_data.push_back(b);
                end else if (ch == tag_store) begin
                    code = $fscanf(fd, "%h %h", a, b);
                    if (code != 2) ok = 1'b0;
                    exp_st_addr.push_back(a);
                    exp_st_data.push_back(b);
                end
                if (ch != -1) ch = $fgetc(fd);
            end
            $fclose(fd);
            if (program_words.size() > imem_depth) ok = 1'b0;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < imem_depth; i++) begin
            imem_we   = 1'b1;
            imem_addr = i[imem_addr_w-1:0];
            if (i < program_words.size()) imem_wdata = program_words[i];
            else imem_wdata = filler_word(i);
            next_cycle();
        end
        imem_we = 1'b0;
    endtask

    task automatic compare_writeback();
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        if (exp_wb_rd.size() == 0) begin
            $display("Unexpected register write at %0t: x%0d = %h after the last expected one",
                     $time, wb_rd, wb_data);
            event_errors++;
        end else begin
            rd   = exp_wb_rd.pop_front();
            data = exp_wb_data.pop_front();
            wb_seen++;
            if (wb_rd != rd || wb_data != data) begin
                $display("ERR %0t: writeback %0d expected x%0d = %h, got x%0d = %h",
                         $time, wb_seen, rd, data, wb_rd, wb_data);
                value_errors++;
            end
        end
    endtask

    task automatic verify_store();
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        if (exp_st_addr.size() == 0) begin
            $display("Unexpected store at %0t: [%h] = %h after the last expected one",
                     $time, st_addr, st_data);
            event_errors++;
        end else begin
            addr = exp_st_addr.pop_front();
            data = exp_st_data.pop_front();
            st_seen++;
            if (st_addr != addr || st_data != data) begin
                $display("ERR %0t: store %0d expected [%h] = %h, got [%h] = %h",
                         $time, st_seen, addr, data, st_addr, st_data);
                value_errors++;
            end
        end
    endtask

    task automatic report_totals();
        $display("Seen %0d/%0d writebacks, %0d/%0d stores; %0d value errors, %0d event errors",
                 wb_seen, n_wb, st_seen, n_st, value_errors, event_errors);
    endtask

    // Outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (wb_valid === 1'b1) compare_writeback();
        if (st_valid === 1'b1) verify_store();
    end

    initial begin
        wait (run === 1'b1);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles of run with expected events still missing",
                 watchdog_cycles);
        report_totals();
        $display("Something failed");
        $finish;
    end

    initial begin
        logic ok;
        reset           = 1'b1;
        run             = 1'b0;
        imem_we         = 1'b0;
        imem_addr       = '0;
        imem_wdata      = '0;
        wb_seen         = 0;
        st_seen         = 0;
        value_errors    = 0;
        event_errors    = 0;
        watchdog_cycles = 0;
        read_stimulus(ok);
        if (!ok) begin
            $display("The stimulus file riscv_stimulus.txt is missing or malformed");
            $display("Something failed");
            $finish;
        end else begin
            n_wb = exp_wb_rd.size();
            n_st = exp_st_addr.size();
            watchdog_cycles = 20 * (n_wb + n_st) + 50;
            repeat (reset_cycles) next_cycle();
            reset = 1'b0;
            load_program();
            run = 1'b1;
            while (wb_seen < n_wb || st_seen < n_st) next_cycle();
            // Program ends in a self-loop, so nothing more may retire.
            repeat (quiet_cycles) next_cycle();
            report_totals();
            if (value_errors == 0 && event_errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: riscv_core.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_core (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              run,
    input  logic                              imem_we,
    input  logic [riscv_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [riscv_pkg::xlen-1:0]        imem_wdata,
    output logic                              wb_valid,
    output logic [riscv_pkg::reg_addr_w-1:0]  wb_rd,
    output logic [riscv_pkg::xlen-1:0]        wb_data,
    output logic                              st_valid,
    output logic [riscv_pkg::xlen-1:0]        st_addr,
    output logic [riscv_pkg::xlen-1:0]        st_data
);
    import riscv_pkg::*;

    logic                  clear, stall, pc_src;
    logic [xlen-1:0]       pc, imem_rdata;
    logic [xlen-1:0]       ifid_pc, ifid_instr;
    logic                  ctl_reg_write, ctl_mem_read, ctl_mem_write, ctl_mem_to_reg;
    logic                  ctl_alu_src, ctl_branch;
    alu_op_t               ctl_alu_op;
    imm_sel_t              ctl_imm_sel;
    fwd_sel_t              fwd_a, fwd_b;
    logic [xlen-1:0]       rf_rdata1, rf_rdata2, id_imm;
    logic                  idex_reg_write, idex_mem_read, idex_mem_write, idex_mem_to_reg;
    logic                  idex_alu_src, idex_branch;
    alu_op_t               idex_alu_op;
    logic [xlen-1:0]       idex_pc, idex_rs1_data, idex_rs2_data, idex_imm;
    logic [reg_addr_w-1:0] idex_rs1, idex_rs2, idex_rd;
    logic [xlen-1:0]       alu_a, fwd_b_data, alu_b, alu_result;
    logic                  alu_zero;
    logic                  exmem_reg_write, exmem_mem_write, exmem_mem_to_reg;
    logic                  exmem_branch, exmem_zero;
    logic [xlen-1:0]       exmem_alu_result, exmem_store_data, exmem_target, dmem_rdata;
    logic [reg_addr_w-1:0] exmem_rd;
    logic                  memwb_reg_write, memwb_mem_to_reg;
    logic [xlen-1:0]       memwb_alu_result, memwb_load_data, wb_result;
    logic [reg_addr_w-1:0] memwb_rd;

    // Pipeline is held empty until the program is loaded and run is raised.
    assign clear  = reset || !run;
    assign pc_src = exmem_branch && exmem_zero;

    always_ff @(posedge clk) begin
        if (clear) pc <= '0;
        else if (pc_src) pc <= exmem_target;
        else if (!stall) pc <= pc + 32'd4;
    end

    riscv_imem i_imem (
        .clk(clk), .we(imem_we && !run), .waddr(imem_addr), .wdata(imem_wdata),
        .raddr(pc[imem_addr_w+1:2]), .rdata(imem_rdata)
    );

    always_ff @(posedge clk) begin
        if (clear || pc_src) ifid_instr <= '0;
        else if (!stall) ifid_instr <= imem_rdata;
    end

    always_ff @(posedge clk) begin
        if (!stall) ifid_pc <= pc;
    end

    riscv_control i_control (
        .if_opcode(ifid_instr[6:0]), .if_funct3(ifid_instr[14:12]),
        .if_funct7b5(ifid_instr[30]), .if_rs1(ifid_instr[19:15]), .if_rs2(ifid_instr[24:20]),
        .ex_mem_read(idex_mem_read), .ex_rd(idex_rd), .ex_rs1(idex_rs1), .ex_rs2(idex_rs2),
        .mem_reg_write(exmem_reg_write), .mem_rd(exmem_rd),
        .wb_reg_write(memwb_reg_write), .wb_rd(memwb_rd),
        .reg_write(ctl_reg_write), .mem_read(ctl_mem_read), .mem_write(ctl_mem_write),
        .mem_to_reg(ctl_mem_to_reg), .alu_src(ctl_alu_src), .branch(ctl_branch),
        .alu_op(ctl_alu_op), .imm_sel(ctl_imm_sel), .stall(stall),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    riscv_regfile i_regfile (
        .clk(clk), .reset(reset), .rs1(ifid_instr[19:15]), .rs2(ifid_instr[24:20]),
        .rd(memwb_rd), .wdata(wb_result), .we(memwb_reg_write),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    riscv_immgen i_immgen (.instr(ifid_instr), .sel(ctl_imm_sel), .imm(id_imm));

    always_ff @(posedge clk) begin
        if (clear || pc_src) begin
            idex_reg_write  <= 1'b0;
            idex_mem_read   <= 1'b0;
            idex_mem_write  <= 1'b0;
            idex_mem_to_reg <= 1'b0;
            idex_alu_src    <= 1'b0;
            idex_branch     <= 1'b0;
            idex_alu_op     <= alu_add;
        end else begin
            idex_reg_write  <= ctl_reg_write;
            idex_mem_read   <= ctl_mem_read;
            idex_mem_write  <= ctl_mem_write;
            idex_mem_to_reg <= ctl_mem_to_reg;
            idex_alu_src    <= ctl_alu_src;
            idex_branch     <= ctl_branch;
            idex_alu_op     <= ctl_alu_op;
        end
    end

    always_ff @(posedge clk) begin
        idex_pc       <= ifid_pc;
        idex_rs1_data <= rf_rdata1;
        idex_rs2_data <= rf_rdata2;
        idex_imm      <= id_imm;
        idex_rs1      <= ifid_instr[19:15];
        idex_rs2      <= ifid_instr[24:20];
        idex_rd       <= ifid_instr[11:7];
    end

    always_comb begin
        case (fwd_a)
            fwd_mem: alu_a = exmem_alu_result;
            fwd_wb:  alu_a = wb_result;
            default: alu_a = idex_rs1_data;
        endcase
        case (fwd_b)
            fwd_mem: fwd_b_data = exmem_alu_result;
            fwd_wb:  fwd_b_data = wb_result;
            default: fwd_b_data = idex_rs2_data;
        endcase
    end

    assign alu_b = idex_alu_src ? idex_imm : fwd_b_data;

    riscv_alu i_alu (.op(idex_alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .zero(alu_zero));

    // The instruction leaving execute is the oldest wrong-path one; drop it too.
    always_ff @(posedge clk) begin
        if (clear || pc_src) begin
            exmem_reg_write  <= 1'b0;
            exmem_mem_write  <= 1'b0;
            exmem_mem_to_reg <= 1'b0;
            exmem_branch     <= 1'b0;
            exmem_zero       <= 1'b0;
        end else begin
            exmem_reg_write  <= idex_reg_write;
            exmem_mem_write  <= idex_mem_write;
            exmem_mem_to_reg <= idex_mem_to_reg;
            exmem_branch     <= idex_branch;
            exmem_zero       <= alu_zero;
        end
    end

    always_ff @(posedge clk) begin
        exmem_alu_result <= alu_result;
        exmem_store_data <= fwd_b_data;
        exmem_target     <= idex_pc + idex_imm;
        exmem_rd         <= idex_rd;
    end

    riscv_dmem i_dmem (
        .clk(clk), .reset(reset), .we(exmem_mem_write),
        .addr(exmem_alu_result[dmem_addr_w+1:2]), .wdata(exmem_store_data), .rdata(dmem_rdata)
    );

    always_ff @(posedge clk) begin
        if (clear) begin
            memwb_reg_write  <= 1'b0;
            memwb_mem_to_reg <= 1'b0;
        end else begin
            memwb_reg_write  <= exmem_reg_write;
            memwb_mem_to_reg <= exmem_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        memwb_alu_result <= exmem_alu_result;
        memwb_load_data  <= dmem_rdata;
        memwb_rd         <= exmem_rd;
    end

    assign wb_result = memwb_mem_to_reg ? memwb_load_data : memwb_alu_result;

    // Retirement and store events.
    assign wb_valid = memwb_reg_write && (memwb_rd != '0);
    assign wb_rd    = memwb_rd;
    assign wb_data  = wb_result;
    assign st_valid = exmem_mem_write;
    assign st_addr  = exmem_alu_result;
    assign st_data  = exmem_store_data;

endmodule

`default_nettype wire

// File: riscv_dmem.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_dmem (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              we,
    input  logic [riscv_pkg::dmem_addr_w-1:0] addr,
    input  logic [riscv_pkg::xlen-1:0]        wdata,
    output logic [riscv_pkg::xlen-1:0]        rdata
);
    import riscv_pkg::*;

    logic [xlen-1:0] mem [dmem_depth];

    // Data memory starts from all zeros.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dmem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: riscv_imem.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_imem (
    input  logic                              clk,
    input  logic                              we,
    input  logic [riscv_pkg::imem_addr_w-1:0] waddr,
    input  logic [riscv_pkg::xlen-1:0]        wdata,
    input  logic [riscv_pkg::imem_addr_w-1:0] raddr,
    output logic [riscv_pkg::xlen-1:0]        rdata
);
    import riscv_pkg::*;

    logic [xlen-1:0] mem [imem_depth];

    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
    end

    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: riscv_immgen.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_immgen (
    input  logic [riscv_pkg::xlen-1:0] instr,
    input  riscv_pkg::imm_sel_t        sel,
    output logic [riscv_pkg::xlen-1:0] imm
);
    import riscv_pkg::*;

    always_comb begin
        case (sel)
            imm_s: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // Branch offset is in halfwords, bit 0 always zero.
            imm_b: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: riscv_alu.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_alu (
    input  riscv_pkg::alu_op_t         op,
    input  logic [riscv_pkg::xlen-1:0] a,
    input  logic [riscv_pkg::xlen-1:0] b,
    output logic [riscv_pkg::xlen-1:0] result,
    output logic                       zero
);
    import riscv_pkg::*;

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            // Signed compare.
            alu_slt: result = {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: riscv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_regfile (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [riscv_pkg::reg_addr_w-1:0] rs1,
    input  logic [riscv_pkg::reg_addr_w-1:0] rs2,
    input  logic [riscv_pkg::reg_addr_w-1:0] rd,
    input  logic [riscv_pkg::xlen-1:0]       wdata,
    input  logic                             we,
    output logic [riscv_pkg::xlen-1:0]       rdata1,
    output logic [riscv_pkg::xlen-1:0]       rdata2
);
    import riscv_pkg::*;

    logic [xlen-1:0] regs [1 << reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write is visible to decode.
    always_comb begin
        rdata1 = regs[rs1];
        rdata2 = regs[rs2];
        if (we && (rd != '0) && (rd == rs1)) rdata1 = wdata;
        if (we && (rd != '0) && (rd == rs2)) rdata2 = wdata;
    end

endmodule

`default_nettype wire

// File: riscv_control.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_control (
    input  logic [6:0]                      if_opcode,
    input  logic [2:0]                      if_funct3,
    input  logic                            if_funct7b5,
    input  logic [riscv_pkg::reg_addr_w-1:0] if_rs1,
    input  logic [riscv_pkg::reg_addr_w-1:0] if_rs2,
    input  logic                            ex_mem_read,
    input  logic [riscv_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [riscv_pkg::reg_addr_w-1:0] ex_rs1,
    input  logic [riscv_pkg::reg_addr_w-1:0] ex_rs2,
    input  logic                            mem_reg_write,
    input  logic [riscv_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                            wb_reg_write,
    input  logic [riscv_pkg::reg_addr_w-1:0] wb_rd,
    output logic                            reg_write,
    output logic                            mem_read,
    output logic                            mem_write,
    output logic                            mem_to_reg,
    output logic                            alu_src,
    output logic                            branch,
    output riscv_pkg::alu_op_t              alu_op,
    output riscv_pkg::imm_sel_t             imm_sel,
    output logic                            stall,
    output riscv_pkg::fwd_sel_t             fwd_a,
    output riscv_pkg::fwd_sel_t             fwd_b
);
    import riscv_pkg::*;

    function automatic alu_op_t alu_decode(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  alu_decode = sub ? alu_sub : alu_add;
            3'b010:  alu_decode = alu_slt;
            3'b110:  alu_decode = alu_or;
            3'b111:  alu_decode = alu_and;
            default: alu_decode = alu_add;
        endcase
    endfunction

    // Load in execute whose result the decoding instruction needs.
    assign stall = ex_mem_read && (ex_rd != '0) && ((ex_rd == if_rs1) || (ex_rd == if_rs2));

    always_comb begin
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        alu_src    = 1'b0;
        branch     = 1'b0;
        alu_op     = alu_add;
        imm_sel    = imm_i;
        case (if_opcode)
            op_rtype: begin
                reg_write = 1'b1;
                alu_op    = alu_decode(if_funct3, if_funct7b5);
            end
            op_itype: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = alu_decode(if_funct3, 1'b0);
            end
            op_load: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                alu_src    = 1'b1;
            end
            op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_sel   = imm_s;
            end
            op_branch: begin
                branch  = 1'b1;
                alu_op  = alu_sub;
                imm_sel = imm_b;
            end
            default: ;
        endcase
        // A stalled slot enters execute as a bubble.
        if (stall) begin
            reg_write = 1'b0;
            mem_read  = 1'b0;
            mem_write = 1'b0;
            branch    = 1'b0;
        end
    end

    // EX/MEM wins over MEM/WB since it holds the younger result.
    assign fwd_a = (mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs1)) ? fwd_mem :
                   (wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs1))    ? fwd_wb  : fwd_reg;
    assign fwd_b = (mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs2)) ? fwd_mem :
                   (wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs2))    ? fwd_wb  : fwd_reg;

endmodule

`default_nettype wire

// File: riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    // Datapath and memory sizes.
    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int imem_depth  = 64;
    localparam int dmem_depth  = 64;
    localparam int imem_addr_w = 6;
    localparam int dmem_addr_w = 6;

    // Major opcodes of the supported subset.
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_slt = 4'd4
    } alu_op_t;

    // Operand source for the execute stage.
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_t;

    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_s = 2'd1,
        imm_b = 2'd2
    } imm_sel_t;

endpackage

`default_nettype wire
